//--- logic/readout_pkg.sv
`default_nettype none

package readout_pkg;

    // Front-end channel count and word layout
    localparam int N_CHANNELS = 4;
    localparam int CH_IDX_W = 2;
    localparam int CH_DATA_W = 28;
    localparam int TAG_W = 4;
    // Tag in the top bits, channel data below
    localparam int WORD_W = TAG_W + CH_DATA_W;

    // Output word FIFO
    localparam int FIFO_DEPTH = 16;
    localparam int PTR_W = 4;
    // One extra bit so a full FIFO counts to 16
    localparam int FILL_W = 5;
    localparam int NEAR_FULL_LEVEL = 12;

    // Trigger-unit channel, may keep its grant
    localparam int HOLD_CHANNEL = 0;

    // Arbiter states
    typedef enum logic {
        ARB_SCAN,
        ARB_HOLD
    } arb_state_t;

endpackage

`default_nettype wire

//--- logic/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // APB bus widths
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // Register offsets
    typedef enum logic [APB_ADDR_W-1:0] {
        CSR_SELECT = 8'h00,
        CSR_STATUS = 8'h04,
        CSR_CLEAR  = 8'h08
    } csr_addr_t;

    // Status register fields
    localparam int STATUS_FILL_LSB = 0;
    localparam int STATUS_FULL_BIT = 8;
    localparam int STATUS_NEAR_FULL_BIT = 9;
    localparam int STATUS_RD_ERR_BIT = 10;

    // Clear command bit
    localparam int CLEAR_RD_ERR_BIT = 0;

endpackage

`default_nettype wire

//--- logic/apb_csr.sv
`timescale 1ns/100ps
`default_nettype none

module apb_csr (
    input  wire                               CLK_40,
    input  wire                               i_rst,
    input  wire                               i_psel,
    input  wire                               i_penable,
    input  wire                               i_pwrite,
    input  wire  [csr_pkg::APB_ADDR_W-1:0]    i_paddr,
    input  wire  [csr_pkg::APB_DATA_W-1:0]    i_pwdata,
    input  wire  [readout_pkg::FILL_W-1:0]    i_fill,
    input  wire                               i_full,
    input  wire                               i_near_full,
    input  wire                               i_rd_underflow,
    output logic [csr_pkg::APB_DATA_W-1:0]    o_prdata,
    output logic [readout_pkg::N_CHANNELS-1:0] o_ch_enable
);

    import csr_pkg::*;
    import readout_pkg::*;

    csr_addr_t             addr;
    logic                  wr_access;
    logic                  clear_cmd;
    logic [N_CHANNELS-1:0] ch_enable;
    logic                  rd_err;
    logic [APB_DATA_W-1:0] status_word;

    // Offsets outside the map fall to the default branches
    assign addr = csr_addr_t'(i_paddr);

    // Writes land in the access phase
    assign wr_access = i_psel && i_penable && i_pwrite;
    assign clear_cmd = wr_access && (addr == CSR_CLEAR) && i_pwdata[CLEAR_RD_ERR_BIT];

    // Channel select mask
    always_ff @(posedge CLK_40) begin
        if (i_rst) begin
            ch_enable <= '0;
        end else if (wr_access && (addr == CSR_SELECT)) begin
            ch_enable <= i_pwdata[N_CHANNELS-1:0];
        end
    end

    // Sticky read error
    // A new underflow wins over a clear in the same cycle
    always_ff @(posedge CLK_40) begin
        if (i_rst) begin
            rd_err <= 1'b0;
        end else if (i_rd_underflow) begin
            rd_err <= 1'b1;
        end else if (clear_cmd) begin
            rd_err <= 1'b0;
        end
    end

    // Status readback
    always_comb begin
        status_word = '0;
        status_word[STATUS_FILL_LSB +: FILL_W] = i_fill;
        status_word[STATUS_FULL_BIT] = i_full;
        status_word[STATUS_NEAR_FULL_BIT] = i_near_full;
        status_word[STATUS_RD_ERR_BIT] = rd_err;
    end

    // Read mux, zero wait states
    always_comb begin
        o_prdata = '0;
        if (i_psel && !i_pwrite) begin
            case (addr)
                CSR_SELECT: o_prdata[N_CHANNELS-1:0] = ch_enable;
                CSR_STATUS: o_prdata = status_word;
                default:    o_prdata = '0;
            endcase
        end
    end

    assign o_ch_enable = ch_enable;

    // Access phase always follows a setup phase with PSEL
    a_penable_needs_psel: assert property (
        @(posedge CLK_40) disable iff (i_rst)
        $rose(i_penable) |-> i_psel
    );

endmodule

`default_nettype wire

//--- logic/channel_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module channel_arbiter (
    input  wire                                                   CLK_40,
    input  wire                                                   i_rst,
    input  wire  [readout_pkg::N_CHANNELS-1:0]                    i_ch_req,
    input  wire  [readout_pkg::N_CHANNELS-1:0][readout_pkg::CH_DATA_W-1:0] i_ch_data,
    input  wire                                                   i_hold_req,
    input  wire  [readout_pkg::N_CHANNELS-1:0]                    i_ch_enable,
    input  wire                                                   i_full,
    output logic [readout_pkg::N_CHANNELS-1:0]                    o_ch_ack,
    output logic                                                  o_wr_en,
    output logic [readout_pkg::WORD_W-1:0]                        o_wr_word
);

    import readout_pkg::*;

    arb_state_t            state;
    logic [CH_IDX_W-1:0]   rr_ptr;
    logic [CH_IDX_W-1:0]   search_start;
    logic [CH_IDX_W-1:0]   cand;
    logic [N_CHANNELS-1:0] eligible;
    logic                  grant_valid;
    logic [CH_IDX_W-1:0]   grant_idx;
    logic [TAG_W-1:0]      grant_tag;

    // Full FIFO vetoes every channel
    assign eligible = i_ch_req & i_ch_enable & {N_CHANNELS{!i_full}};

    // Channel 0 keeps first priority while it holds
    assign search_start = (state == ARB_HOLD && i_hold_req) ?
                          CH_IDX_W'(HOLD_CHANNEL) : rr_ptr;

    // Rotating search from the start pointer
    always_comb begin
        grant_valid = 1'b0;
        grant_idx = '0;
        cand = '0;
        for (int n = 0; n < N_CHANNELS; n++) begin
            // Index wraps with the pointer width
            cand = CH_IDX_W'(search_start + n);
            if (!grant_valid && eligible[cand]) begin
                grant_valid = 1'b1;
                grant_idx = cand;
            end
        end
    end

    // One-hot acknowledge
    always_comb begin
        o_ch_ack = '0;
        if (grant_valid) begin
            o_ch_ack[grant_idx] = 1'b1;
        end
    end

    // Tag is channel index plus one
    assign grant_tag = TAG_W'(grant_idx) + TAG_W'(1);
    assign o_wr_en = grant_valid;
    assign o_wr_word = {grant_tag, i_ch_data[grant_idx]};

    // Pointer and hold state
    always_ff @(posedge CLK_40) begin
        if (i_rst) begin
            state <= ARB_SCAN;
            rr_ptr <= '0;
        end else if (grant_valid) begin
            rr_ptr <= grant_idx + 1'b1;
            if (grant_idx == CH_IDX_W'(HOLD_CHANNEL) && i_hold_req) begin
                state <= ARB_HOLD;
            end else begin
                state <= ARB_SCAN;
            end
        end else if (!i_hold_req) begin
            // Hold dropped while nothing granted
            state <= ARB_SCAN;
        end
    end

    a_ack_onehot: assert property (
        @(posedge CLK_40) disable iff (i_rst)
        $onehot0(o_ch_ack)
    );

    // Full flag comes from the FIFO
    a_no_write_when_full: assert property (
        @(posedge CLK_40) disable iff (i_rst)
        i_full |-> !o_wr_en
    );

endmodule

`default_nettype wire

//--- logic/word_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module word_fifo (
    input  wire                            CLK_40,
    input  wire                            i_rst,
    input  wire                            i_wr_en,
    input  wire  [readout_pkg::WORD_W-1:0] i_wr_word,
    input  wire                            i_rd_en,
    output logic [readout_pkg::WORD_W-1:0] o_rd_word,
    output logic [readout_pkg::FILL_W-1:0] o_fill,
    output logic                           o_empty,
    output logic                           o_full,
    output logic                           o_near_full
);

    import readout_pkg::*;

    logic [WORD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [FILL_W-1:0] fill;
    logic              wr_ok;
    logic              rd_ok;

    // Guard against overflow and underflow
    assign wr_ok = i_wr_en && !o_full;
    assign rd_ok = i_rd_en && !o_empty;

    // Storage
    always_ff @(posedge CLK_40) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_wr_word;
        end
    end

    // Pointers wrap at the depth
    always_ff @(posedge CLK_40) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Fill count, push with pop leaves it unchanged
    always_ff @(posedge CLK_40) begin
        if (i_rst) begin
            fill <= '0;
        end else if (wr_ok && !rd_ok) begin
            fill <= fill + 1'b1;
        end else if (rd_ok && !wr_ok) begin
            fill <= fill - 1'b1;
        end
    end

    // Oldest word, shown ahead of the pop
    assign o_rd_word = mem[rd_ptr];
    assign o_fill = fill;
    assign o_empty = (fill == '0);
    assign o_full = (fill == FILL_W'(FIFO_DEPTH));
    assign o_near_full = (fill >= FILL_W'(NEAR_FULL_LEVEL));

    a_fill_bound: assert property (
        @(posedge CLK_40) disable iff (i_rst)
        fill <= FILL_W'(FIFO_DEPTH)
    );

endmodule

`default_nettype wire

//--- logic/readout_port.sv
`timescale 1ns/100ps
`default_nettype none

module readout_port (
    input  wire                            CLK_40,
    input  wire                            i_rst,
    input  wire                            i_rd_req,
    input  wire                            i_empty,
    input  wire  [readout_pkg::WORD_W-1:0] i_fifo_word,
    output logic                           o_fifo_pop,
    output logic [readout_pkg::WORD_W-1:0] o_rd_data,
    output logic                           o_rd_valid,
    output logic                           o_underflow
);

    import readout_pkg::*;

    logic              pop;
    logic [WORD_W-1:0] rd_data;
    logic              rd_valid;

    // Pop only when there is something to pop
    assign pop = i_rd_req && !i_empty;

    // Request against empty FIFO
    assign o_underflow = i_rd_req && i_empty;

    // Valid flag one cycle after the pop
    always_ff @(posedge CLK_40) begin
        if (i_rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= pop;
        end
    end

    // Popped word, held until the next pop
    always_ff @(posedge CLK_40) begin
        if (pop) begin
            rd_data <= i_fifo_word;
        end
    end

    assign o_fifo_pop = pop;
    assign o_rd_data = rd_data;
    assign o_rd_valid = rd_valid;

endmodule

`default_nettype wire

//--- logic/readout_top.sv
`timescale 1ns/100ps
`default_nettype none

module readout_top (
    input  wire                                                   CLK_40,
    input  wire                                                   i_rst,
    // APB
    input  wire                                                   i_psel,
    input  wire                                                   i_penable,
    input  wire                                                   i_pwrite,
    input  wire  [csr_pkg::APB_ADDR_W-1:0]                        i_paddr,
    input  wire  [csr_pkg::APB_DATA_W-1:0]                        i_pwdata,
    output logic [csr_pkg::APB_DATA_W-1:0]                        o_prdata,
    // Front-end channels
    input  wire  [readout_pkg::N_CHANNELS-1:0]                    i_ch_req,
    input  wire  [readout_pkg::N_CHANNELS-1:0][readout_pkg::CH_DATA_W-1:0] i_ch_data,
    input  wire                                                   i_hold_req,
    output logic [readout_pkg::N_CHANNELS-1:0]                    o_ch_ack,
    // Host readout
    input  wire                                                   i_rd_req,
    output logic [readout_pkg::WORD_W-1:0]                        o_rd_data,
    output logic                                                  o_rd_valid,
    output logic                                                  o_rd_empty
);

    import readout_pkg::*;

    logic [N_CHANNELS-1:0] ch_enable;
    logic                  wr_en;
    logic [WORD_W-1:0]     wr_word;
    logic [WORD_W-1:0]     fifo_word;
    logic [FILL_W-1:0]     fill;
    logic                  fifo_empty;
    logic                  fifo_full;
    logic                  fifo_near_full;
    logic                  fifo_pop;
    logic                  rd_underflow;

    // Register block
    apb_csr u_apb_csr (
        .CLK_40         (CLK_40),
        .i_rst          (i_rst),
        .i_psel         (i_psel),
        .i_penable      (i_penable),
        .i_pwrite       (i_pwrite),
        .i_paddr        (i_paddr),
        .i_pwdata       (i_pwdata),
        .i_fill         (fill),
        .i_full         (fifo_full),
        .i_near_full    (fifo_near_full),
        .i_rd_underflow (rd_underflow),
        .o_prdata       (o_prdata),
        .o_ch_enable    (ch_enable)
    );

    // Producer side
    channel_arbiter u_channel_arbiter (
        .CLK_40      (CLK_40),
        .i_rst       (i_rst),
        .i_ch_req    (i_ch_req),
        .i_ch_data   (i_ch_data),
        .i_hold_req  (i_hold_req),
        .i_ch_enable (ch_enable),
        .i_full      (fifo_full),
        .o_ch_ack    (o_ch_ack),
        .o_wr_en     (wr_en),
        .o_wr_word   (wr_word)
    );

    // Output buffer
    word_fifo u_word_fifo (
        .CLK_40      (CLK_40),
        .i_rst       (i_rst),
        .i_wr_en     (wr_en),
        .i_wr_word   (wr_word),
        .i_rd_en     (fifo_pop),
        .o_rd_word   (fifo_word),
        .o_fill      (fill),
        .o_empty     (fifo_empty),
        .o_full      (fifo_full),
        .o_near_full (fifo_near_full)
    );

    // Host side
    readout_port u_readout_port (
        .CLK_40      (CLK_40),
        .i_rst       (i_rst),
        .i_rd_req    (i_rd_req),
        .i_empty     (fifo_empty),
        .i_fifo_word (fifo_word),
        .o_fifo_pop  (fifo_pop),
        .o_rd_data   (o_rd_data),
        .o_rd_valid  (o_rd_valid),
        .o_underflow (rd_underflow)
    );

    assign o_rd_empty = fifo_empty;

endmodule

`default_nettype wire

//--- test/readout_checker.sv
`timescale 1ns/100ps
`default_nettype none

module readout_checker (
    input  wire                                                   CLK_40,
    input  wire                                                   i_rst,
    input  wire                                                   i_psel,
    input  wire                                                   i_penable,
    input  wire                                                   i_pwrite,
    input  wire  [csr_pkg::APB_ADDR_W-1:0]                        i_paddr,
    input  wire  [csr_pkg::APB_DATA_W-1:0]                        i_pwdata,
    input  wire  [csr_pkg::APB_DATA_W-1:0]                        i_prdata,
    input  wire  [readout_pkg::N_CHANNELS-1:0]                    i_ch_req,
    input  wire  [readout_pkg::N_CHANNELS-1:0][readout_pkg::CH_DATA_W-1:0] i_ch_data,
    input  wire                                                   i_hold_req,
    input  wire  [readout_pkg::N_CHANNELS-1:0]                    i_ch_ack,
    input  wire                                                   i_rd_req,
    input  wire  [readout_pkg::WORD_W-1:0]                        i_rd_data,
    input  wire                                                   i_rd_valid,
    input  wire                                                   i_rd_empty,
    output int                                                    o_errors,
    output int                                                    o_words_read,
    output int                                                    o_acks
);

    import readout_pkg::*;
    import csr_pkg::*;

    // Reference model of the FIFO contents, oldest word first
    logic [WORD_W-1:0]     model_q [$];
    logic [N_CHANNELS-1:0] mask_m;
    int                    ptr_m;
    logic                  hold_m;
    logic                  rd_err_m;
    logic                  pend_valid;
    logic [WORD_W-1:0]     pend_word;
    int                    errors = 0;
    int                    words_read = 0;
    int                    acks = 0;

    assign o_errors = errors;
    assign o_words_read = words_read;
    assign o_acks = acks;

    // First enabled requester from the start channel, nothing while full
    function automatic logic [N_CHANNELS-1:0] expected_ack(
        input logic [N_CHANNELS-1:0] req,
        input logic [N_CHANNELS-1:0] en,
        input logic                  full,
        input int                    start
    );
        logic [N_CHANNELS-1:0] ack;
        int                    ch;
        ack = '0;
        if (!full) begin
            for (int n = 0; n < N_CHANNELS; n++) begin
                ch = (start + n) % N_CHANNELS;
                if (ack == '0 && req[ch] && en[ch]) begin
                    ack[ch] = 1'b1;
                end
            end
        end
        return ack;
    endfunction

    always @(posedge CLK_40) begin : check_edge
        int                    fill;
        int                    start;
        logic                  empty_m;
        logic                  full_m;
        logic                  underflow;
        logic                  granted;
        logic [N_CHANNELS-1:0] ack_m;
        logic [APB_DATA_W-1:0] rd_exp;
        if (i_rst) begin
            model_q.delete();
            mask_m = '0;
            ptr_m = 0;
            hold_m = 1'b0;
            rd_err_m = 1'b0;
            pend_valid = 1'b0;
        end else begin
            // Model state as seen before this edge
            fill = model_q.size();
            empty_m = (fill == 0);
            full_m = (fill == FIFO_DEPTH);

            // Word popped at the previous edge
            if (i_rd_valid !== pend_valid) begin
                $display("ERROR at %0t: rd_valid %b, expected %b", $time, i_rd_valid,
                         pend_valid);
                errors++;
            end else if (pend_valid) begin
                words_read++;
                if (i_rd_data !== pend_word) begin
                    $display("ERROR at %0t: read word %h, expected %h", $time, i_rd_data,
                             pend_word);
                    errors++;
                end
            end
            if (i_rd_empty !== empty_m) begin
                $display("ERROR at %0t: rd_empty %b, model fill %0d", $time, i_rd_empty,
                         fill);
                errors++;
            end

            // Channel 0 keeps first place while it holds
            start = (hold_m && i_hold_req) ? HOLD_CHANNEL : ptr_m;
            ack_m = expected_ack(i_ch_req, mask_m, full_m, start);
            if (i_ch_ack !== ack_m) begin
                $display("ERROR at %0t: ack %b, expected %b", $time, i_ch_ack, ack_m);
                errors++;
            end

            // Register readback in the access phase
            if (i_psel && i_penable && !i_pwrite) begin
                rd_exp = '0;
                if (i_paddr == CSR_SELECT) begin
                    rd_exp[N_CHANNELS-1:0] = mask_m;
                end else if (i_paddr == CSR_STATUS) begin
                    rd_exp[FILL_W-1:0] = FILL_W'(fill);
                    rd_exp[STATUS_FULL_BIT] = full_m;
                    rd_exp[STATUS_NEAR_FULL_BIT] = (fill >= NEAR_FULL_LEVEL);
                    rd_exp[STATUS_RD_ERR_BIT] = rd_err_m;
                end
                if (i_prdata !== rd_exp) begin
                    $display("ERROR at %0t: read of %h gave %h, expected %h", $time,
                             i_paddr, i_prdata, rd_exp);
                    errors++;
                end
            end

            // Pop sees only words stored before this edge
            pend_valid = 1'b0;
            underflow = i_rd_req && empty_m;
            if (i_rd_req && !empty_m) begin
                pend_word = model_q.pop_front();
                pend_valid = 1'b1;
            end

            // Tag is index plus one
            granted = 1'b0;
            for (int g = 0; g < N_CHANNELS; g++) begin
                if (ack_m[g]) begin
                    model_q.push_back({TAG_W'(g + 1), i_ch_data[g]});
                    acks++;
                    granted = 1'b1;
                    ptr_m = (g + 1) % N_CHANNELS;
                    hold_m = (g == HOLD_CHANNEL) && i_hold_req;
                end
            end
            if (!granted && !i_hold_req) begin
                hold_m = 1'b0;
            end

            // Register writes, new underflow beats a clear
            if (underflow) begin
                rd_err_m = 1'b1;
            end else if (i_psel && i_penable && i_pwrite && i_paddr == CSR_CLEAR &&
                         i_pwdata[0]) begin
                rd_err_m = 1'b0;
            end
            if (i_psel && i_penable && i_pwrite && i_paddr == CSR_SELECT) begin
                mask_m = i_pwdata[N_CHANNELS-1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_readout.sv
`timescale 1ns/100ps
`default_nettype none

module tb_readout;

    import readout_pkg::*;
    import csr_pkg::*;

    // Phase lengths in cycles
    localparam int RESET_CYC = 16;
    localparam int APB_CYC = 3;
    localparam int N_MASKS = 8;
    localparam int MASK_RUN = 40;
    localparam int RANDOM_CYC = 400;
    localparam int STATUS_EVERY = 50;
    localparam int ROTATE_RUN = 40;
    localparam int FILL_CYC = 120;
    localparam int DRAIN_CYC = 120;
    localparam int PHASE_CYC = RESET_CYC + 2 * APB_CYC + N_MASKS * (2 * APB_CYC + MASK_RUN)
                               + RANDOM_CYC + 2 * ROTATE_RUN + FILL_CYC + DRAIN_CYC
                               + 6 * APB_CYC;
    localparam int CYCLE_LIMIT = 2 * PHASE_CYC;

    logic                                  CLK_40;
    logic                                  rst;
    logic                                  psel;
    logic                                  penable;
    logic                                  pwrite;
    logic [APB_ADDR_W-1:0]                 paddr;
    logic [APB_DATA_W-1:0]                 pwdata;
    logic [APB_DATA_W-1:0]                 prdata;
    logic [N_CHANNELS-1:0]                 ch_req;
    logic [N_CHANNELS-1:0][CH_DATA_W-1:0] ch_data;
    logic                                  hold_req;
    logic [N_CHANNELS-1:0]                 ch_ack;
    logic                                  rd_req;
    logic [WORD_W-1:0]                     rd_data;
    logic                                  rd_valid;
    logic                                  rd_empty;

    // Traffic rates out of 256
    int          req_rate;
    int          rd_rate;
    logic [31:0] chan_rng;
    logic [31:0] cfg_rng;
    int          cycle_count;
    int          tb_errors;
    int          chk_errors;
    int          chk_words;
    int          chk_acks;

    readout_top DUT (
        .CLK_40     (CLK_40),
        .i_rst      (rst),
        .i_psel     (psel),
        .i_penable  (penable),
        .i_pwrite   (pwrite),
        .i_paddr    (paddr),
        .i_pwdata   (pwdata),
        .o_prdata   (prdata),
        .i_ch_req   (ch_req),
        .i_ch_data  (ch_data),
        .i_hold_req (hold_req),
        .o_ch_ack   (ch_ack),
        .i_rd_req   (rd_req),
        .o_rd_data  (rd_data),
        .o_rd_valid (rd_valid),
        .o_rd_empty (rd_empty)
    );

    readout_checker u_checker (
        .CLK_40       (CLK_40),
        .i_rst        (rst),
        .i_psel       (psel),
        .i_penable    (penable),
        .i_pwrite     (pwrite),
        .i_paddr      (paddr),
        .i_pwdata     (pwdata),
        .i_prdata     (prdata),
        .i_ch_req     (ch_req),
        .i_ch_data    (ch_data),
        .i_hold_req   (hold_req),
        .i_ch_ack     (ch_ack),
        .i_rd_req     (rd_req),
        .i_rd_data    (rd_data),
        .i_rd_valid   (rd_valid),
        .i_rd_empty   (rd_empty),
        .o_errors     (chk_errors),
        .o_words_read (chk_words),
        .o_acks       (chk_acks)
    );

    // LCG step
    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        CLK_40 = 1'b0;
        forever #5 CLK_40 = ~CLK_40;
    end

    // APB write with setup then access phase
    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                             input logic [APB_DATA_W-1:0] data);
        @(posedge CLK_40);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge CLK_40);
        penable <= 1'b1;
        @(posedge CLK_40);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
    endtask

    // APB read with data taken at the access edge
    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
                            output logic [APB_DATA_W-1:0] data);
        @(posedge CLK_40);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge CLK_40);
        penable <= 1'b1;
        @(posedge CLK_40);
        data = prdata;
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    // Channel and host traffic
    // A request stays up with its data until acknowledged
    always @(posedge CLK_40) begin
        if (!rst) begin
            for (int ch = 0; ch < N_CHANNELS; ch++) begin
                if (!(ch_req[ch] && !ch_ack[ch])) begin
                    chan_rng = lcg_step(chan_rng);
                    if (int'(chan_rng[31:24]) < req_rate) begin
                        ch_req[ch] <= 1'b1;
                        chan_rng = lcg_step(chan_rng);
                        ch_data[ch] <= chan_rng[CH_DATA_W-1:0];
                    end else begin
                        ch_req[ch] <= 1'b0;
                    end
                end
            end
            chan_rng = lcg_step(chan_rng);
            rd_req <= (int'(chan_rng[31:24]) < rd_rate);
        end
    end

    // Run limit
    always @(posedge CLK_40) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin : main
        logic [APB_DATA_W-1:0] rdata;
        logic [N_CHANNELS-1:0] mask;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        ch_req = '0;
        ch_data = '0;
        hold_req = 1'b0;
        rd_req = 1'b0;
        req_rate = 0;
        rd_rate = 0;
        chan_rng = 32'd77;
        cfg_rng = 32'd77;
        cycle_count = 0;
        tb_errors = 0;
        repeat (RESET_CYC) @(posedge CLK_40);
        rst <= 1'b0;

        // Idle after reset with status all zero
        apb_read(CSR_STATUS, rdata);
        apb_read(CSR_SELECT, rdata);

        // Random masks with light traffic
        req_rate <= 128;
        rd_rate <= 64;
        for (int m = 0; m < N_MASKS; m++) begin
            cfg_rng = lcg_step(cfg_rng);
            mask = cfg_rng[27:24];
            apb_write(CSR_SELECT, APB_DATA_W'(mask));
            apb_read(CSR_SELECT, rdata);
            repeat (MASK_RUN) @(posedge CLK_40);
        end

        // All channels with random traffic and reads
        apb_write(CSR_SELECT, APB_DATA_W'(4'hf));
        req_rate <= 160;
        rd_rate <= 160;
        repeat (RANDOM_CYC / STATUS_EVERY) begin
            apb_read(CSR_STATUS, rdata);
            repeat (STATUS_EVERY - APB_CYC) @(posedge CLK_40);
        end

        // Continuous requests for round robin then channel 0 hold
        req_rate <= 256;
        rd_rate <= 256;
        repeat (ROTATE_RUN) @(posedge CLK_40);
        hold_req <= 1'b1;
        repeat (ROTATE_RUN) @(posedge CLK_40);
        hold_req <= 1'b0;

        // No reads until the FIFO is full
        rd_rate <= 0;
        rdata = '0;
        while (!rdata[STATUS_FULL_BIT]) begin
            apb_read(CSR_STATUS, rdata);
        end
        repeat (20) @(posedge CLK_40);
        apb_read(CSR_STATUS, rdata);

        // Drain then read against an empty FIFO
        req_rate <= 0;
        rd_rate <= 256;
        @(posedge CLK_40);
        while (!(rd_empty && ch_req == '0)) begin
            @(posedge CLK_40);
        end
        repeat (4) @(posedge CLK_40);
        rd_rate <= 0;
        repeat (2) @(posedge CLK_40);
        apb_read(CSR_STATUS, rdata);
        if (!rdata[STATUS_RD_ERR_BIT]) begin
            $display("ERROR at %0t: read error bit clear after reads from the empty FIFO",
                     $time);
            tb_errors++;
        end
        apb_write(CSR_CLEAR, APB_DATA_W'(1));
        apb_read(CSR_STATUS, rdata);

        repeat (4) @(posedge CLK_40);
        if (chk_words == 0 || chk_acks == 0) begin
            $display("No words were acknowledged or read out during the run");
            tb_errors++;
        end
        $display("Errors: checker %0d, testbench %0d (words read %0d, acks %0d)",
                 chk_errors, tb_errors, chk_words, chk_acks);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
logic/readout_pkg.sv
logic/csr_pkg.sv
logic/apb_csr.sv
logic/channel_arbiter.sv
logic/word_fifo.sv
logic/readout_port.sv
logic/readout_top.sv
test/readout_checker.sv
test/tb_readout.sv
